//--- rtl/bimodalPredictor.sv
`timescale 1ns/1ps

module bimodalPredictor import fetchPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] pc0,
    input  logic [ADDR_WIDTH-1:0] pc1,
    input  logic                  isBr0,
    input  logic                  isBr1,
    output BpdInfo                bpd0,
    output BpdInfo                bpd1,
    input  logic                  resolveValid,
    input  logic [ADDR_WIDTH-1:0] resolvePc,
    input  logic                  resolveTaken
);
    logic [1:0]                counters [BHT_ENTRIES];
    logic [BHT_INDEX_BITS-1:0] idx0;
    logic [BHT_INDEX_BITS-1:0] idx1;
    logic [BHT_INDEX_BITS-1:0] resolveIdx;

    assign idx0       = pc0[2 +: BHT_INDEX_BITS];          // word address
    assign idx1       = pc1[2 +: BHT_INDEX_BITS];
    assign resolveIdx = resolvePc[2 +: BHT_INDEX_BITS];

    assign bpd0.valid = isBr0;
    assign bpd0.taken = isBr0 && (counters[idx0] >= BIM_WEAK_TAKEN);
    assign bpd1.valid = isBr1;
    assign bpd1.taken = isBr1 && (counters[idx1] >= BIM_WEAK_TAKEN);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                counters[i] <= BIM_WEAK_NOT_TAKEN;
            end
        end else if (resolveValid) begin
            counters[resolveIdx] <= bimStep(counters[resolveIdx], resolveTaken);
        end
    end

endmodule

//--- rtl/branchCheck.sv
`timescale 1ns/1ps

module branchCheck import fetchPkg::*; (
    FetchBundleIntf.consumer      bundleIn,
    output logic [ADDR_WIDTH-1:0] pc0,
    output logic [ADDR_WIDTH-1:0] pc1,
    output logic                  isBr0,
    output logic                  isBr1,
    input  BpdInfo                bpd0,
    input  BpdInfo                bpd1,
    RedirectIntf.source           redirectOut,
    NlpUpdateIntf.writer          nlpOut,
    output logic                  outValid,
    input  logic                  outReady,
    output logic [ADDR_WIDTH-1:0] outPc0,
    output logic [31:0]           outInst0,
    output logic                  outSlotValid0,
    output logic [ADDR_WIDTH-1:0] outPc1,
    output logic [31:0]           outInst1,
    output logic                  outSlotValid1,
    output logic                  outPredTaken,
    output logic [ADDR_WIDTH-1:0] outPredTarget
);
    SlotInfo               slot0;
    SlotInfo               slot1;
    logic                  isJ0;
    logic                  isJ1;
    logic                  isJr0;
    logic                  isJr1;
    logic [ADDR_WIDTH-1:0] staticTarget0;
    logic [ADDR_WIDTH-1:0] staticTarget1;
    logic                  predTaken0;
    logic                  predTaken1;
    logic [ADDR_WIDTH-1:0] predAddr0;
    logic [ADDR_WIDTH-1:0] predAddr1;
    logic                  nlpTaken0;
    logic                  nlpTaken1;
    logic                  transfer;

    function automatic logic decideTaken(input logic valid, input logic isJ, input logic isBr,
                                         input BpdInfo bpd, input NlpInfo nlp);
        if (!valid)     return 1'b0;
        if (isJ)        return 1'b1;
        if (!isBr)      return 1'b0;
        if (bpd.valid)  return bpd.taken;
        if (nlp.valid)  return nlp.taken;
        return 1'b0;                                       // both miss
    endfunction

    function automatic NlpUpdate makeUpdate(input SlotInfo slot, input logic [ADDR_WIDTH-1:0] target,
                                            input logic shouldTake, input logic doWrite);
        NlpUpdate upd;
        upd.valid      = doWrite;
        upd.pc         = slot.pc;
        upd.target     = target;
        upd.bimState   = slot.nlpInfo.valid ? slot.nlpInfo.bimState : BIM_WEAK_TAKEN;
        upd.shouldTake = shouldTake;
        return upd;
    endfunction

    assign slot0 = bundleIn.slot0;
    assign slot1 = bundleIn.slot1;
    assign pc0   = slot0.pc;
    assign pc1   = slot1.pc;

    predecoder preDec0 (
        .pc     (slot0.pc),
        .inst   (slot0.inst),
        .valid  (slot0.valid),
        .isJ    (isJ0),
        .isJr   (isJr0),
        .isBr   (isBr0),
        .target (staticTarget0)
    );

    predecoder preDec1 (
        .pc     (slot1.pc),
        .inst   (slot1.inst),
        .valid  (slot1.valid),
        .isJ    (isJ1),
        .isJr   (isJr1),
        .isBr   (isBr1),
        .target (staticTarget1)
    );

    // a JR is only followed when the NLP knows where it goes
    assign predTaken0 = decideTaken(slot0.valid, isJ0, isBr0, bpd0, slot0.nlpInfo)
                        && !(isJr0 && !slot0.nlpInfo.valid);
    assign predTaken1 = decideTaken(slot1.valid, isJ1, isBr1, bpd1, slot1.nlpInfo)
                        && !(isJr1 && !slot1.nlpInfo.valid);
    assign predAddr0  = isJr0 ? slot0.nlpInfo.target : staticTarget0;
    assign predAddr1  = isJr1 ? slot1.nlpInfo.target : staticTarget1;
    assign nlpTaken0  = slot0.valid && slot0.nlpInfo.valid && slot0.nlpInfo.taken;
    assign nlpTaken1  = slot1.valid && slot1.nlpInfo.valid && slot1.nlpInfo.taken;

    assign transfer        = bundleIn.valid && outReady;
    assign bundleIn.ready  = outReady;

    always_comb begin
        redirectOut.redirect   = 1'b0;
        redirectOut.redirectPc = slot0.pc + 4;
        if (predTaken0 != nlpTaken0) begin
            redirectOut.redirect   = transfer;
            redirectOut.redirectPc = predTaken0 ? predAddr0 : slot0.pc + 4;
        end else if (!predTaken0 && (predTaken1 != nlpTaken1)) begin
            redirectOut.redirect   = transfer;
            redirectOut.redirectPc = predTaken1 ? predAddr1 : slot1.pc + 4;
        end
    end

    always_comb begin
        if (bpd0.valid || (isJ0 && (!isJr0 || slot0.nlpInfo.valid))) begin
            nlpOut.update = makeUpdate(slot0, predAddr0, predTaken0, transfer);
        end else if (bpd1.valid || (isJ1 && (!isJr1 || slot1.nlpInfo.valid))) begin
            nlpOut.update = makeUpdate(slot1, predAddr1, predTaken1, transfer);
        end else begin
            nlpOut.update = makeUpdate(slot0, predAddr0, predTaken0, 1'b0);
        end
    end

    assign outValid      = bundleIn.valid;
    assign outPc0        = slot0.pc;
    assign outInst0      = slot0.inst;
    assign outSlotValid0 = slot0.valid;
    assign outPc1        = slot1.pc;
    assign outInst1      = slot1.inst;
    assign outSlotValid1 = slot1.valid && !predTaken0;      // killed behind a taken slot 0
    assign outPredTaken  = predTaken0 || predTaken1;
    assign outPredTarget = predTaken0 ? predAddr0 :
                           predTaken1 ? predAddr1 : slot1.pc + 4;

endmodule

//--- rtl/fetchFrontend.sv
`timescale 1ns/1ps

module fetchFrontend import fetchPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic [ADDR_WIDTH-1:0] imemAddr,
    input  logic [63:0]           imemData,
    input  logic                  resolveValid,
    input  logic [ADDR_WIDTH-1:0] resolvePc,
    input  logic                  resolveTaken,
    output logic                  outValid,
    input  logic                  outReady,
    output logic [ADDR_WIDTH-1:0] outPc0,
    output logic [31:0]           outInst0,
    output logic                  outSlotValid0,
    output logic [ADDR_WIDTH-1:0] outPc1,
    output logic [31:0]           outInst1,
    output logic                  outSlotValid1,
    output logic                  outPredTaken,
    output logic [ADDR_WIDTH-1:0] outPredTarget
);
    FetchBundleIntf fetchToQueue ();
    FetchBundleIntf queueToCheck ();
    RedirectIntf    redirectBus ();
    NlpUpdateIntf   nlpUpdateBus ();

    logic [ADDR_WIDTH-1:0] nlpPc;
    NlpInfo                nlpInfo0;
    NlpInfo                nlpInfo1;
    logic [ADDR_WIDTH-1:0] bpdPc0;
    logic [ADDR_WIDTH-1:0] bpdPc1;
    logic                  bpdIsBr0;
    logic                  bpdIsBr1;
    BpdInfo                bpd0;
    BpdInfo                bpd1;

    fetchPcGen fetchPcGen_i (
        .clk        (clk),
        .reset      (reset),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .nlpPc      (nlpPc),
        .nlpInfo0   (nlpInfo0),
        .nlpInfo1   (nlpInfo1),
        .fetchOut   (fetchToQueue.producer),
        .redirectIn (redirectBus.sink)
    );

    nextLinePredictor nextLinePredictor_i (
        .clk      (clk),
        .reset    (reset),
        .lookupPc (nlpPc),
        .info0    (nlpInfo0),
        .info1    (nlpInfo1),
        .updateIn (nlpUpdateBus.nlpTable)
    );

    fetchQueue fetchQueue_i (
        .clk      (clk),
        .reset    (reset),
        .pushSide (fetchToQueue.consumer),
        .popSide  (queueToCheck.producer),
        .flushIn  (redirectBus.sink)
    );

    branchCheck branchCheck_i (
        .bundleIn      (queueToCheck.consumer),
        .pc0           (bpdPc0),
        .pc1           (bpdPc1),
        .isBr0         (bpdIsBr0),
        .isBr1         (bpdIsBr1),
        .bpd0          (bpd0),
        .bpd1          (bpd1),
        .redirectOut   (redirectBus.source),
        .nlpOut        (nlpUpdateBus.writer),
        .outValid      (outValid),
        .outReady      (outReady),
        .outPc0        (outPc0),
        .outInst0      (outInst0),
        .outSlotValid0 (outSlotValid0),
        .outPc1        (outPc1),
        .outInst1      (outInst1),
        .outSlotValid1 (outSlotValid1),
        .outPredTaken  (outPredTaken),
        .outPredTarget (outPredTarget)
    );

    bimodalPredictor bimodalPredictor_i (
        .clk          (clk),
        .reset        (reset),
        .pc0          (bpdPc0),
        .pc1          (bpdPc1),
        .isBr0        (bpdIsBr0),
        .isBr1        (bpdIsBr1),
        .bpd0         (bpd0),
        .bpd1         (bpd1),
        .resolveValid (resolveValid),
        .resolvePc    (resolvePc),
        .resolveTaken (resolveTaken)
    );

endmodule

//--- rtl/fetchIntf.sv
`timescale 1ns/1ps

interface FetchBundleIntf import fetchPkg::*; ();
    logic    valid;
    logic    ready;
    SlotInfo slot0;
    SlotInfo slot1;

    modport producer (
        output valid,
        output slot0,
        output slot1,
        input  ready
    );

    modport consumer (
        input  valid,
        input  slot0,
        input  slot1,
        output ready
    );
endinterface

interface RedirectIntf import fetchPkg::*; ();
    logic                  redirect;
    logic [ADDR_WIDTH-1:0] redirectPc;

    modport source (output redirect, output redirectPc);
    modport sink   (input  redirect, input  redirectPc);
endinterface

interface NlpUpdateIntf import fetchPkg::*; ();
    NlpUpdate update;

    modport writer   (output update);
    modport nlpTable (input  update);
endinterface

//--- rtl/fetchPcGen.sv
`timescale 1ns/1ps

module fetchPcGen import fetchPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic [ADDR_WIDTH-1:0] imemAddr,
    input  logic [63:0]           imemData,
    output logic [ADDR_WIDTH-1:0] nlpPc,
    input  NlpInfo                nlpInfo0,
    input  NlpInfo                nlpInfo1,
    FetchBundleIntf.producer      fetchOut,
    RedirectIntf.sink             redirectIn
);
    logic [ADDR_WIDTH-1:0] fetchPc;
    logic [ADDR_WIDTH-1:0] alignedPc;
    logic [ADDR_WIDTH-1:0] nextPc;
    logic                  slotValid0;
    logic                  push;

    assign alignedPc  = {fetchPc[ADDR_WIDTH-1:3], 3'b000};
    assign imemAddr   = alignedPc;
    assign nlpPc      = alignedPc;
    assign slotValid0 = !fetchPc[2];                       // entered at the upper word
    assign push       = fetchOut.valid && fetchOut.ready;

    always_comb begin
        fetchOut.valid               = 1'b1;
        fetchOut.slot0.pc            = alignedPc;
        fetchOut.slot0.inst          = imemData[31:0];
        fetchOut.slot0.valid         = slotValid0;
        fetchOut.slot0.nlpInfo       = nlpInfo0;
        fetchOut.slot0.nlpInfo.valid = nlpInfo0.valid && slotValid0;
        fetchOut.slot1.pc            = alignedPc + 4;
        fetchOut.slot1.inst          = imemData[63:32];
        fetchOut.slot1.valid         = 1'b1;
        fetchOut.slot1.nlpInfo       = nlpInfo1;
    end

    always_comb begin
        if (slotValid0 && nlpInfo0.valid && nlpInfo0.taken) begin
            nextPc = nlpInfo0.target;
        end else if (nlpInfo1.valid && nlpInfo1.taken) begin
            nextPc = nlpInfo1.target;
        end else begin
            nextPc = alignedPc + 8;                        // sequential bundle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc <= RESET_PC;
        end else if (redirectIn.redirect) begin
            fetchPc <= redirectIn.redirectPc;
        end else if (push) begin
            fetchPc <= nextPc;
        end
    end

endmodule

//--- rtl/fetchPkg.sv
package fetchPkg;

    localparam int              ADDR_WIDTH         = 32;
    localparam logic [31:0]     RESET_PC           = 32'h0000_0000;
    localparam int              QUEUE_DEPTH        = 4;
    localparam int              QUEUE_PTR_BITS     = $clog2(QUEUE_DEPTH);
    localparam int              NLP_ENTRIES        = 16;
    localparam int              NLP_INDEX_BITS     = $clog2(NLP_ENTRIES);
    localparam int              BHT_ENTRIES        = 64;
    localparam int              BHT_INDEX_BITS     = $clog2(BHT_ENTRIES);
    localparam logic [1:0]      BIM_WEAK_TAKEN     = 2'b10;
    localparam logic [1:0]      BIM_WEAK_NOT_TAKEN = 2'b01;

    localparam logic [5:0]      OP_SPECIAL = 6'h00;
    localparam logic [5:0]      OP_J       = 6'h02;
    localparam logic [5:0]      OP_JAL     = 6'h03;
    localparam logic [5:0]      OP_BEQ     = 6'h04;
    localparam logic [5:0]      OP_BNE     = 6'h05;
    localparam logic [5:0]      OP_BLEZ    = 6'h06;
    localparam logic [5:0]      OP_BGTZ    = 6'h07;
    localparam logic [5:0]      FN_JR      = 6'h08;
    localparam logic [5:0]      FN_JALR    = 6'h09;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } RFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } IFields;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } JFields;

    typedef union packed {
        RFields rFields;
        IFields iFields;
        JFields jFields;
    } InstWord;

    typedef struct packed {
        logic                  valid;
        logic                  taken;
        logic [ADDR_WIDTH-1:0] target;
        logic [1:0]            bimState;
    } NlpInfo;

    typedef struct packed {
        logic valid;
        logic taken;
    } BpdInfo;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        InstWord               inst;
        logic                  valid;
        NlpInfo                nlpInfo;
    } SlotInfo;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc;
        logic [ADDR_WIDTH-1:0] target;
        logic [1:0]            bimState;
        logic                  shouldTake;
    } NlpUpdate;

    // saturating 2-bit counter step
    function automatic logic [1:0] bimStep(input logic [1:0] state, input logic taken);
        if (taken) begin
            return (state == 2'b11) ? state : state + 2'b01;
        end
        return (state == 2'b00) ? state : state - 2'b01;
    endfunction

endpackage

//--- rtl/fetchQueue.sv
`timescale 1ns/1ps

module fetchQueue import fetchPkg::*; (
    input  logic             clk,
    input  logic             reset,
    FetchBundleIntf.consumer pushSide,
    FetchBundleIntf.producer popSide,
    RedirectIntf.sink        flushIn
);
    SlotInfo                   slot0Mem [QUEUE_DEPTH];
    SlotInfo                   slot1Mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_BITS-1:0] wrPtr;
    logic [QUEUE_PTR_BITS-1:0] rdPtr;
    logic [QUEUE_PTR_BITS:0]   count;
    logic                      push;
    logic                      pop;

    assign pushSide.ready = (count != QUEUE_DEPTH[QUEUE_PTR_BITS:0]);
    assign popSide.valid  = (count != '0);
    assign popSide.slot0  = slot0Mem[rdPtr];
    assign popSide.slot1  = slot1Mem[rdPtr];

    assign push = pushSide.valid && pushSide.ready;
    assign pop  = popSide.valid && popSide.ready;

    always_ff @(posedge clk) begin
        if (reset || flushIn.redirect) begin               // flush drops a same-cycle push
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flushIn.redirect) begin
            slot0Mem[wrPtr] <= pushSide.slot0;
            slot1Mem[wrPtr] <= pushSide.slot1;
        end
    end

endmodule

//--- rtl/nextLinePredictor.sv
`timescale 1ns/1ps

module nextLinePredictor import fetchPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] lookupPc,
    output NlpInfo                info0,
    output NlpInfo                info1,
    NlpUpdateIntf.nlpTable        updateIn
);
    logic [ADDR_WIDTH-1:0]     tagPc    [NLP_ENTRIES];
    logic [ADDR_WIDTH-1:0]     targetPc [NLP_ENTRIES];
    logic [1:0]                bimState [NLP_ENTRIES];
    logic [NLP_ENTRIES-1:0]    entryValid;
    logic [NLP_INDEX_BITS-1:0] rdIdx;
    logic [NLP_INDEX_BITS-1:0] wrIdx;
    logic                      entryTaken;

    assign rdIdx      = lookupPc[3 +: NLP_INDEX_BITS];     // one entry per bundle
    assign wrIdx      = updateIn.update.pc[3 +: NLP_INDEX_BITS];
    assign entryTaken = bimState[rdIdx] >= BIM_WEAK_TAKEN;

    always_comb begin
        info0.valid    = entryValid[rdIdx] && (tagPc[rdIdx] == lookupPc);
        info0.taken    = entryTaken;
        info0.target   = targetPc[rdIdx];
        info0.bimState = bimState[rdIdx];

        info1.valid    = entryValid[rdIdx] && (tagPc[rdIdx] == lookupPc + 4);
        info1.taken    = entryTaken;
        info1.target   = targetPc[rdIdx];
        info1.bimState = bimState[rdIdx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (updateIn.update.valid) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updateIn.update.valid) begin
            tagPc[wrIdx]    <= updateIn.update.pc;
            targetPc[wrIdx] <= updateIn.update.target;
            bimState[wrIdx] <= bimStep(updateIn.update.bimState, updateIn.update.shouldTake);
        end
    end

endmodule

//--- rtl/predecoder.sv
`timescale 1ns/1ps

module predecoder import fetchPkg::*; (
    input  logic [ADDR_WIDTH-1:0] pc,
    input  InstWord               inst,
    input  logic                  valid,
    output logic                  isJ,
    output logic                  isJr,
    output logic                  isBr,
    output logic [ADDR_WIDTH-1:0] target
);
    logic [ADDR_WIDTH-1:0] pcPlus4;
    logic [ADDR_WIDTH-1:0] brOffset;

    assign pcPlus4  = pc + 4;
    assign brOffset = {{(ADDR_WIDTH-18){inst.iFields.imm16[15]}}, inst.iFields.imm16, 2'b00};

    always_comb begin
        isJ    = 1'b0;
        isJr   = 1'b0;
        isBr   = 1'b0;
        target = pcPlus4 + brOffset;
        case (inst.jFields.opcode)
            OP_J, OP_JAL: begin
                isJ    = valid;
                target = {pcPlus4[ADDR_WIDTH-1:28], inst.jFields.index26, 2'b00};
            end
            OP_SPECIAL: begin
                if (inst.rFields.funct == FN_JR || inst.rFields.funct == FN_JALR) begin
                    isJ  = valid;
                    isJr = valid;                          // target only known to the NLP
                end
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: isBr = valid;
            default: isBr = 1'b0;
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetchFrontendTb -f sim.f -o fetchFrontendSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetchFrontendSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- sim.f
rtl/fetchPkg.sv
rtl/fetchIntf.sv
rtl/predecoder.sv
rtl/nextLinePredictor.sv
rtl/fetchPcGen.sv
rtl/fetchQueue.sv
rtl/bimodalPredictor.sv
rtl/branchCheck.sv
rtl/fetchFrontend.sv
verif/fetchFrontendTb.sv

//--- verif/fetchFrontendTb.sv
`timescale 1ns/1ps

module fetchFrontendTb;

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_TESTS      = 6;
    localparam int BUNDLE_TOTAL   = 55;                    // expected bundles over all tests
    localparam int TIMEOUT_CYCLES = 40 * BUNDLE_TOTAL + NUM_TESTS * (RESET_CYCLES + 8);

    logic        clk;
    logic        reset;
    logic [31:0] imemAddr;
    logic [63:0] imemData;
    logic        resolveValid;
    logic [31:0] resolvePc;
    logic        resolveTaken;
    logic        outValid;
    logic        outReady;
    logic [31:0] outPc0;
    logic [31:0] outInst0;
    logic        outSlotValid0;
    logic [31:0] outPc1;
    logic [31:0] outInst1;
    logic        outSlotValid1;
    logic        outPredTaken;
    logic [31:0] outPredTarget;

    logic [31:0] mem [256];
    logic [1:0]  bimModel [64];
    logic [31:0] goldPc;                                   // next bundle on the predicted path
    int          checks;
    int          errors;

    // same-cycle memory with slot 0 in the low word
    assign imemData = {mem[imemAddr[9:2] + 8'd1], mem[imemAddr[9:2]]};

    fetchFrontend fetchFrontend_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] jumpTo(input logic [31:0] target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic logic [31:0] bneTo(input logic [31:0] pc, input logic [31:0] target);
        logic [31:0] offset;
        offset = (target - pc - 32'd4) >> 2;
        return {6'h05, 5'd1, 5'd2, offset[15:0]};
    endfunction

    // taken decision of one valid slot on the predicted path
    function automatic logic slotTaken(input logic [31:0] pc, input logic [31:0] word,
                                       output logic [31:0] target);
        logic [31:0] pcPlus4;
        logic [31:0] offset;
        pcPlus4 = pc + 32'd4;
        offset  = {{14{word[15]}}, word[15:0], 2'b00};
        target  = pcPlus4 + offset;
        case (word[31:26])
            6'h02, 6'h03: begin
                target = {pcPlus4[31:28], word[25:0], 2'b00};
                return 1'b1;
            end
            6'h04, 6'h05, 6'h06, 6'h07: return bimModel[pc[7:2]] >= 2'b10;
            default: return 1'b0;                          // jr never learns a target here
        endcase
    endfunction

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     testName, field, expected, actual);
        end
    endtask

    task automatic checkBundle(input string testName);
        logic [31:0] aligned;
        logic [31:0] word0;
        logic [31:0] word1;
        logic [31:0] target0;
        logic [31:0] target1;
        logic        slot0Valid;
        logic        taken0;
        logic        taken1;
        aligned    = {goldPc[31:3], 3'b000};
        slot0Valid = !goldPc[2];
        word0      = mem[aligned[9:2]];
        word1      = mem[aligned[9:2] + 8'd1];
        taken0     = slotTaken(aligned, word0, target0);
        taken0     = taken0 && slot0Valid;
        taken1     = slotTaken(aligned + 32'd4, word1, target1);
        checkValue(testName, "pc0", aligned, outPc0);
        checkValue(testName, "inst0", word0, outInst0);
        checkValue(testName, "slot valid 0", 32'(slot0Valid), 32'(outSlotValid0));
        checkValue(testName, "pc1", aligned + 32'd4, outPc1);
        checkValue(testName, "inst1", word1, outInst1);
        checkValue(testName, "slot valid 1", 32'(!taken0), 32'(outSlotValid1));
        checkValue(testName, "pred taken", 32'(taken0 || taken1), 32'(outPredTaken));
        if (taken0 || taken1) begin
            checkValue(testName, "pred target", taken0 ? target0 : target1, outPredTarget);
        end
        goldPc = taken0 ? target0 : (taken1 ? target1 : aligned + 32'd8);
    endtask

    task automatic runBundles(input string testName, input int count, input logic randomReady);
        logic transferred;
        for (int i = 0; i < count; i++) begin
            transferred = 1'b0;
            while (!transferred) begin
                @(negedge clk);
                outReady = randomReady ? ($urandom_range(0, 1) == 1) : 1'b1;
                if (outValid && outReady) begin            // transfer at the next rising edge
                    checkBundle(testName);
                    transferred = 1'b1;
                end
            end
        end
        @(negedge clk);
        outReady = 1'b0;
    endtask

    task automatic resetDut();
        reset        = 1'b1;
        outReady     = 1'b0;
        resolveValid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset  = 1'b0;
        goldPc = 32'h0;
        for (int i = 0; i < 64; i++) begin
            bimModel[i] = 2'b01;                           // weakly not taken
        end
    endtask

    task automatic resolveBranch(input logic [31:0] pc, input logic taken);
        @(negedge clk);
        resolveValid = 1'b1;
        resolvePc    = pc;
        resolveTaken = taken;
        @(negedge clk);
        resolveValid = 1'b0;
        if (taken && bimModel[pc[7:2]] != 2'b11) begin
            bimModel[pc[7:2]] = bimModel[pc[7:2]] + 2'b01;
        end else if (!taken && bimModel[pc[7:2]] != 2'b00) begin
            bimModel[pc[7:2]] = bimModel[pc[7:2]] - 2'b01;
        end
    endtask

    task automatic loadFill();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {6'h08, 10'h000, 16'(i)};             // addi with the word index
        end
    endtask

    task automatic testStraightLine();
        loadFill();
        resetDut();
        runBundles("straight line", 8, 1'b0);
    endtask

    task automatic testJumpLoop();
        loadFill();
        mem[4]  = jumpTo(32'h40);
        mem[20] = jumpTo(32'h00);                          // back to the start from 0x50
        resetDut();
        runBundles("jump loop", 14, 1'b0);
    endtask

    task automatic testBranchTraining(input string testName, input logic randomReady);
        loadFill();
        mem[3]  = bneTo(32'h0c, 32'h30);                   // slot 1 of bundle 0x08
        mem[10] = jumpTo(32'h00);
        mem[14] = jumpTo(32'h00);
        resetDut();
        runBundles(testName, 6, randomReady);
        resolveBranch(32'h0c, 1'b1);
        resolveBranch(32'h0c, 1'b1);
        runBundles(testName, 6, randomReady);
    endtask

    task automatic testJrFallThrough();
        loadFill();
        mem[2] = 32'h03e0_0008;                            // jr r31 in slot 0
        mem[5] = 32'h03e0_f809;                            // jalr in slot 1
        resetDut();
        runBundles("jr fall through", 4, 1'b0);
    endtask

    task automatic testOddTarget();
        loadFill();
        mem[2] = jumpTo(32'h24);
        resetDut();
        runBundles("odd target", 5, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hdf99_2c96));
        reset        = 1'b1;
        outReady     = 1'b0;
        resolveValid = 1'b0;
        resolvePc    = 32'h0;
        resolveTaken = 1'b0;
        checks       = 0;
        errors       = 0;
        testStraightLine();
        testJumpLoop();
        testBranchTraining("bne training", 1'b0);
        testJrFallThrough();
        testOddTarget();
        testBranchTraining("random ready", 1'b1);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the front end stopped delivering bundles",
                 TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
